// File: rtl/simmem_params.svh
/* Width and size macros for the write-response bank:
   message, identifier and slot-pool dimensions */

`ifndef SIMMEM_PARAMS_SVH
`define SIMMEM_PARAMS_SVH

// Full write-response word, identifier in the low bits
`define SIMMEM_MSG_W 32

// AXI identifier field width
`define SIMMEM_ID_W 2

// Size of the slot pool
`define SIMMEM_NUM_SLOTS 8

// Derived sizes
`define SIMMEM_NUM_IDS (1 << `SIMMEM_ID_W)
`define SIMMEM_ADDR_W $clog2(`SIMMEM_NUM_SLOTS)

`endif

// File: rtl/simmem_pkg.sv
/* Shared vector types of the write-response bank */

`include "simmem_params.svh"

package simmem_pkg;

  // Write response word
  typedef logic [`SIMMEM_MSG_W-1:0] msg_t;

  // AXI identifier
  typedef logic [`SIMMEM_ID_W-1:0] id_t;

  // Binary slot index
  typedef logic [`SIMMEM_ADDR_W-1:0] slot_addr_t;

  // One bit per slot
  typedef logic [`SIMMEM_NUM_SLOTS-1:0] slot_mask_t;

  // One bit per identifier
  typedef logic [`SIMMEM_NUM_IDS-1:0] id_mask_t;

endpackage

// File: rtl/simmem_slot_alloc.sv
/* Slot occupancy tracking with lowest-free-slot grant
   and clearing of released slots */

`timescale 1ns/1ps
`include "simmem_params.svh"

module simmem_slot_alloc import simmem_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       reservation_req_ready_i,
  input  slot_mask_t released_slots_i,
  output logic       reservation_req_valid_o,
  output slot_addr_t new_reserved_addr_o,
  output logic       reserve_fire_o
);

  slot_mask_t occupied_q;
  slot_mask_t occupied_d;
  slot_mask_t grant_mask;

  ////////////////////////////////
  // Lowest free slot
  ////////////////////////////////

  // Priority scan from slot 0 upwards
  always_comb begin
    logic found;
    found = 1'b0;
    new_reserved_addr_o = '0;
    for (int s = 0; s < `SIMMEM_NUM_SLOTS; s++) begin
      if (!occupied_q[s] && !found) begin
        new_reserved_addr_o = slot_addr_t'(s);
        found = 1'b1;
      end
    end
  end

  assign reservation_req_valid_o = ~&occupied_q;
  assign reserve_fire_o = reservation_req_valid_o && reservation_req_ready_i;

  ////////////////////////////////
  // Occupancy update
  ////////////////////////////////

  assign grant_mask = reserve_fire_o ? (slot_mask_t'(1) << new_reserved_addr_o) : '0;

  // A granted slot is free, a released one occupied, so the two never overlap
  assign occupied_d = (occupied_q | grant_mask) & ~released_slots_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      occupied_q <= '0;
    end else begin
      occupied_q <= occupied_d;
    end
  end

endmodule

// File: rtl/simmem_id_queues.sv
/* Per-identifier linked-list queues: head, fill and tail pointers,
   counters, next-slot table and input acceptance */

`timescale 1ns/1ps
`include "simmem_params.svh"

module simmem_id_queues import simmem_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       reserve_fire_i,
  input  id_mask_t   reservation_req_id_onehot_i,
  input  slot_addr_t reserved_addr_i,
  input  logic       in_valid_i,
  input  id_t        in_id_i,
  input  id_mask_t   pop_id_onehot_i,
  output logic       in_ready_o,
  output slot_addr_t fill_addr_o,
  output logic       write_en_o,
  output slot_addr_t head_addr_o [`SIMMEM_NUM_IDS],
  output id_mask_t   head_filled_o
);

  typedef logic [`SIMMEM_ADDR_W:0] cnt_t;

  // Oldest unreleased, oldest unfilled and newest reserved slot
  slot_addr_t head_q [`SIMMEM_NUM_IDS];
  slot_addr_t head_d [`SIMMEM_NUM_IDS];
  slot_addr_t fill_q [`SIMMEM_NUM_IDS];
  slot_addr_t fill_d [`SIMMEM_NUM_IDS];
  slot_addr_t tail_q [`SIMMEM_NUM_IDS];
  slot_addr_t tail_d [`SIMMEM_NUM_IDS];

  // Reserved but unfilled, and filled but not popped
  cnt_t unfilled_q [`SIMMEM_NUM_IDS];
  cnt_t unfilled_d [`SIMMEM_NUM_IDS];
  cnt_t filled_q [`SIMMEM_NUM_IDS];
  cnt_t filled_d [`SIMMEM_NUM_IDS];

  slot_addr_t next_q [`SIMMEM_NUM_SLOTS];

  // Queue still holds entries once this cycle's pop is done
  id_mask_t   live;
  logic       in_fire;
  logic       link_en;
  slot_addr_t link_tail;

  ////////////////////////////////
  // Input acceptance
  ////////////////////////////////

  assign in_ready_o  = (unfilled_q[in_id_i] != '0);
  assign in_fire     = in_valid_i && in_ready_o;
  assign write_en_o  = in_fire;
  assign fill_addr_o = fill_q[in_id_i];

  ////////////////////////////////
  // Pointer and counter update
  ////////////////////////////////

  for (genvar i = 0; i < `SIMMEM_NUM_IDS; i++) begin : gen_id
    logic rsv_x;
    logic fill_x;
    logic pop_x;

    assign rsv_x  = reserve_fire_i && reservation_req_id_onehot_i[i];
    assign fill_x = in_fire && (in_id_i == id_t'(i));
    assign pop_x  = pop_id_onehot_i[i];
    assign live[i] = (unfilled_q[i] != '0) || (filled_q[i] > cnt_t'(pop_x));

    assign head_addr_o[i]   = head_q[i];
    assign head_filled_o[i] = (filled_q[i] != '0);

    always_comb begin
      head_d[i]     = head_q[i];
      fill_d[i]     = fill_q[i];
      tail_d[i]     = tail_q[i];
      unfilled_d[i] = unfilled_q[i];
      filled_d[i]   = filled_q[i];

      // Head follows the list, or restarts on an emptied queue
      if (rsv_x && !live[i]) begin
        head_d[i] = reserved_addr_i;
      end else if (pop_x) begin
        head_d[i] = next_q[head_q[i]];
      end

      // Fill pointer restarts when no unfilled slot remains
      if (rsv_x && (unfilled_q[i] == cnt_t'(fill_x))) begin
        fill_d[i] = reserved_addr_i;
      end else if (fill_x) begin
        fill_d[i] = next_q[fill_q[i]];
      end

      if (rsv_x) begin
        tail_d[i] = reserved_addr_i;
      end

      if (rsv_x && !fill_x) begin
        unfilled_d[i] = unfilled_q[i] + cnt_t'(1);
      end else if (!rsv_x && fill_x) begin
        unfilled_d[i] = unfilled_q[i] - cnt_t'(1);
      end

      if (fill_x && !pop_x) begin
        filled_d[i] = filled_q[i] + cnt_t'(1);
      end else if (!fill_x && pop_x) begin
        filled_d[i] = filled_q[i] - cnt_t'(1);
      end
    end
  end

  // At most one reservation per cycle, so one link write
  assign link_en = reserve_fire_i && |(reservation_req_id_onehot_i & live);

  always_comb begin
    link_tail = '0;
    for (int i = 0; i < `SIMMEM_NUM_IDS; i++) begin
      if (reservation_req_id_onehot_i[i]) begin
        link_tail = tail_q[i];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      head_q     <= '{default: '0};
      fill_q     <= '{default: '0};
      tail_q     <= '{default: '0};
      unfilled_q <= '{default: '0};
      filled_q   <= '{default: '0};
      next_q     <= '{default: '0};
    end else begin
      head_q     <= head_d;
      fill_q     <= fill_d;
      tail_q     <= tail_d;
      unfilled_q <= unfilled_d;
      filled_q   <= filled_d;
      if (link_en) begin
        next_q[link_tail] <= reserved_addr_i;
      end
    end
  end

endmodule

// File: rtl/simmem_msg_store.sv
/* Message register array, one word per slot, same-cycle read */

`timescale 1ns/1ps
`include "simmem_params.svh"

module simmem_msg_store import simmem_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       write_en_i,
  input  slot_addr_t write_addr_i,
  input  msg_t       data_i,
  input  slot_addr_t read_addr_i,
  output msg_t       data_o
);

  msg_t mem_q [`SIMMEM_NUM_SLOTS];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_q <= '{default: '0};
    end else if (write_en_i) begin
      mem_q[write_addr_i] <= data_i;
    end
  end

  // Slot being written is unfilled, so it is never read in the same cycle
  assign data_o = mem_q[read_addr_i];

endmodule

// File: rtl/simmem_release_sel.sv
/* Release eligibility, lowest-identifier arbitration,
   output register and release report */

`timescale 1ns/1ps
`include "simmem_params.svh"

module simmem_release_sel import simmem_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  slot_mask_t release_en_i,
  input  slot_addr_t head_addr_i [`SIMMEM_NUM_IDS],
  input  id_mask_t   head_filled_i,
  input  msg_t       read_data_i,
  input  logic       out_ready_i,
  output slot_addr_t read_addr_o,
  output id_mask_t   pop_id_onehot_o,
  output logic       out_valid_o,
  output msg_t       data_o,
  output slot_mask_t addr_released_onehot_o
);

  id_mask_t   eligible;
  id_mask_t   sel_onehot;
  logic       load_ok;
  logic       out_fire;
  msg_t       data_q;
  slot_addr_t slot_q;

  ////////////////////////////////
  // Arbitration
  ////////////////////////////////

  // Only a filled head with its enable bit can leave
  for (genvar i = 0; i < `SIMMEM_NUM_IDS; i++) begin : gen_elig
    assign eligible[i] = head_filled_i[i] && release_en_i[head_addr_i[i]];
  end

  // Isolate the lowest set bit
  assign sel_onehot = eligible & (~eligible + id_mask_t'(1));

  always_comb begin
    read_addr_o = '0;
    for (int i = 0; i < `SIMMEM_NUM_IDS; i++) begin
      if (sel_onehot[i]) begin
        read_addr_o = head_addr_i[i];
      end
    end
  end

  ////////////////////////////////
  // Output register
  ////////////////////////////////

  assign out_fire        = out_valid_o && out_ready_i;
  assign load_ok         = !out_valid_o || out_ready_i;
  assign pop_id_onehot_o = load_ok ? sel_onehot : '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_valid_o <= 1'b0;
    end else if (load_ok) begin
      out_valid_o <= |eligible;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_ok && |eligible) begin
      data_q <= read_data_i;
      slot_q <= read_addr_o;
    end
  end

  assign data_o = data_q;
  assign addr_released_onehot_o = out_fire ? (slot_mask_t'(1) << slot_q) : '0;

endmodule

// File: rtl/simmem_resp_bank.sv
/* Write-response bank top: slot allocator, identifier queues,
   message store and release selector */

`timescale 1ns/1ps
`include "simmem_params.svh"

module simmem_resp_bank import simmem_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  id_mask_t   reservation_req_id_onehot_i,
  input  logic       reservation_req_ready_i,
  output logic       reservation_req_valid_o,
  output slot_addr_t new_reserved_addr_o,
  input  msg_t       data_i,
  input  logic       in_valid_i,
  output logic       in_ready_o,
  input  slot_mask_t release_en_i,
  output slot_mask_t addr_released_onehot_o,
  output msg_t       data_o,
  output logic       out_valid_o,
  input  logic       out_ready_i
);

  id_t        in_id;
  logic       reserve_fire;
  slot_addr_t fill_addr;
  logic       write_en;
  slot_addr_t head_addr [`SIMMEM_NUM_IDS];
  id_mask_t   head_filled;
  id_mask_t   pop_id_onehot;
  slot_addr_t read_addr;
  msg_t       read_data;

  // AXI identifier sits in the low bits of the response
  assign in_id = data_i[`SIMMEM_ID_W-1:0];

  simmem_slot_alloc u_slot_alloc (
    .clk_i                   (clk_i),
    .rst_ni                  (rst_ni),
    .reservation_req_ready_i (reservation_req_ready_i),
    .released_slots_i        (addr_released_onehot_o),
    .reservation_req_valid_o (reservation_req_valid_o),
    .new_reserved_addr_o     (new_reserved_addr_o),
    .reserve_fire_o          (reserve_fire)
  );

  simmem_id_queues u_id_queues (
    .clk_i                       (clk_i),
    .rst_ni                      (rst_ni),
    .reserve_fire_i              (reserve_fire),
    .reservation_req_id_onehot_i (reservation_req_id_onehot_i),
    .reserved_addr_i             (new_reserved_addr_o),
    .in_valid_i                  (in_valid_i),
    .in_id_i                     (in_id),
    .pop_id_onehot_i             (pop_id_onehot),
    .in_ready_o                  (in_ready_o),
    .fill_addr_o                 (fill_addr),
    .write_en_o                  (write_en),
    .head_addr_o                 (head_addr),
    .head_filled_o               (head_filled)
  );

  simmem_msg_store u_msg_store (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .write_en_i   (write_en),
    .write_addr_i (fill_addr),
    .data_i       (data_i),
    .read_addr_i  (read_addr),
    .data_o       (read_data)
  );

  simmem_release_sel u_release_sel (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .release_en_i           (release_en_i),
    .head_addr_i            (head_addr),
    .head_filled_i          (head_filled),
    .read_data_i            (read_data),
    .out_ready_i            (out_ready_i),
    .read_addr_o            (read_addr),
    .pop_id_onehot_o        (pop_id_onehot),
    .out_valid_o            (out_valid_o),
    .data_o                 (data_o),
    .addr_released_onehot_o (addr_released_onehot_o)
  );

endmodule

// File: bench/simmem_resp_bank_chk.sv
/* Bound port assertions for the write-response bank */

`timescale 1ns/1ps
`include "simmem_params.svh"

module simmem_resp_bank_chk import simmem_pkg::*; (
  input logic       clk_i,
  input logic       rst_ni,
  input logic       reservation_req_ready_i,
  input logic       reservation_req_valid_o,
  input logic       in_ready_o,
  input slot_mask_t addr_released_onehot_o,
  input msg_t       data_o,
  input logic       out_valid_o,
  input logic       out_ready_i
);

  // Set by the first reservation after reset
  logic reserved_q;

  // Number of assertion failures so far
  int unsigned fail_count = 0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      reserved_q <= 1'b0;
    end else if (reservation_req_valid_o && reservation_req_ready_i) begin
      reserved_q <= 1'b1;
    end
  end

  hold_under_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(data_o))
    else begin
      fail_count++;
      $error("Output register changed while stalled");
    end

  release_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(addr_released_onehot_o) &&
    ((addr_released_onehot_o == '0) || (out_valid_o && out_ready_i)))
    else begin
      fail_count++;
      $error("Release report is not one-hot or comes outside a handshake");
    end

  no_input_before_reserve: assert property (@(posedge clk_i) disable iff (!rst_ni)
    reservation_req_valid_o && !reserved_q |-> !in_ready_o)
    else begin
      fail_count++;
      $error("Input accepted before any slot was reserved");
    end

endmodule

bind simmem_resp_bank simmem_resp_bank_chk u_chk (.*);

// File: bench/simmem_resp_bank_tb.sv
/* Testbench for the write-response bank: clock, reset,
   commands read from the test file, checks and watchdog */

`timescale 1ns/1ps
`include "simmem_params.svh"

module simmem_resp_bank_tb;

  typedef logic [`SIMMEM_MSG_W-1:0]     msg_bits_t;
  typedef logic [`SIMMEM_NUM_IDS-1:0]   id_bits_t;
  typedef logic [`SIMMEM_NUM_SLOTS-1:0] slot_bits_t;
  typedef logic [`SIMMEM_ADDR_W-1:0]    slot_idx_t;
  typedef logic [8*24-1:0]              name_t;

  localparam string test_file = "bench/simmem_tests.txt";

  logic       clk_i = 1'b0;
  logic       rst_ni;
  id_bits_t   reservation_req_id_onehot_i;
  logic       reservation_req_ready_i;
  logic       reservation_req_valid_o;
  slot_idx_t  new_reserved_addr_o;
  msg_bits_t  data_i;
  logic       in_valid_i;
  logic       in_ready_o;
  slot_bits_t release_en_i;
  slot_bits_t addr_released_onehot_o;
  msg_bits_t  data_o;
  logic       out_valid_o;
  logic       out_ready_i;

  // Fields of a release command
  slot_idx_t  en_list [`SIMMEM_NUM_SLOTS];
  msg_bits_t  exp_msgs [`SIMMEM_NUM_SLOTS];
  slot_idx_t  exp_slots [`SIMMEM_NUM_SLOTS];

  simmem_resp_bank dut (.*);

  always #2 clk_i = ~clk_i;

  // Any failure of the bound checker ends the run
  always @(dut.u_chk.fail_count) begin
    if (dut.u_chk.fail_count != 0) begin
      $display("An assertion of the bound checker failed");
      $display("tests failed");
      $fatal(1, "checker failure");
    end
  end

  task automatic check_value(input name_t name, input string what,
                             input msg_bits_t exp, input msg_bits_t act);
    assert (exp === act) else begin
      $display("Mismatch in %0s (%0s): expected %0h, actual %0h", name, what, exp, act);
      $display("tests failed");
      $fatal(1, "stopped at first error");
    end
  endtask

  task automatic reserve_slot(input name_t name, input int id, input slot_idx_t exp_slot);
    @(negedge clk_i);
    reservation_req_id_onehot_i = id_bits_t'(1) << id;
    reservation_req_ready_i = 1'b1;
    #1;
    while (!reservation_req_valid_o) begin
      @(negedge clk_i);
      #1;
    end
    check_value(name, "granted slot", msg_bits_t'(exp_slot), msg_bits_t'(new_reserved_addr_o));
    @(negedge clk_i);
    reservation_req_ready_i = 1'b0;
    reservation_req_id_onehot_i = '0;
  endtask

  task automatic write_msg(input name_t name, input msg_bits_t msg, input logic ready_exp);
    @(negedge clk_i);
    data_i = msg;
    in_valid_i = 1'b1;
    #1;
    if (ready_exp) begin
      while (!in_ready_o) begin
        @(negedge clk_i);
        #1;
      end
    end else begin
      check_value(name, "in_ready", 0, msg_bits_t'(in_ready_o));
    end
    @(negedge clk_i);
    in_valid_i = 1'b0;
  endtask

  task automatic release_slots(input name_t name, input int n_en, input int stall,
                               input int n_out);
    slot_bits_t en_mask;
    en_mask = '0;
    for (int i = 0; i < n_en; i++) begin
      en_mask[en_list[slot_idx_t'(i)]] = 1'b1;
    end
    @(negedge clk_i);
    release_en_i = en_mask;
    for (int k = 0; k < n_out; k++) begin
      #1;
      while (!out_valid_o) begin
        @(negedge clk_i);
        #1;
      end
      repeat (stall) begin
        @(negedge clk_i);
        #1;
        check_value(name, "out_valid under stall", 1, msg_bits_t'(out_valid_o));
        check_value(name, "data under stall", exp_msgs[slot_idx_t'(k)], data_o);
      end
      @(negedge clk_i);
      out_ready_i = 1'b1;
      #1;
      check_value(name, "released message", exp_msgs[slot_idx_t'(k)], data_o);
      check_value(name, "released slot",
                  msg_bits_t'(slot_bits_t'(1) << exp_slots[slot_idx_t'(k)]),
                  msg_bits_t'(addr_released_onehot_o));
      @(negedge clk_i);
      out_ready_i = 1'b0;
      release_en_i[exp_slots[slot_idx_t'(k)]] = 1'b0;
    end
    release_en_i = '0;
  endtask

  // Enable on an unfilled head must not bring anything out
  task automatic expect_no_output(input name_t name, input slot_idx_t slot, input int cycles);
    @(negedge clk_i);
    release_en_i = slot_bits_t'(1) << slot;
    repeat (cycles) begin
      @(negedge clk_i);
      #1;
      check_value(name, "out_valid", 0, msg_bits_t'(out_valid_o));
    end
    @(negedge clk_i);
    release_en_i = '0;
  endtask

  task automatic fill_bank(input name_t name, input int id, input int exp_count);
    int count;
    count = 0;
    @(negedge clk_i);
    reservation_req_id_onehot_i = id_bits_t'(1) << id;
    reservation_req_ready_i = 1'b1;
    #1;
    while (reservation_req_valid_o) begin
      @(negedge clk_i);
      count++;
      #1;
    end
    @(negedge clk_i);
    reservation_req_ready_i = 1'b0;
    reservation_req_id_onehot_i = '0;
    check_value(name, "reservations until full", exp_count, count);
    check_value(name, "reservation valid", 0, msg_bits_t'(reservation_req_valid_o));
  endtask

  ////////////////////////////////
  // Command loop
  ////////////////////////////////

  initial begin : main
    int               fd;
    int               rc;
    name_t            name;
    logic [7:0]       op;
    logic [8*128-1:0] skip;
    int               f_id;
    int               f_num;
    slot_idx_t        f_slot;
    msg_bits_t        f_msg;
    int               n_en;
    int               stall;
    int               n_out;

    rst_ni = 1'b0;
    reservation_req_id_onehot_i = '0;
    reservation_req_ready_i = 1'b0;
    data_i = '0;
    in_valid_i = 1'b0;
    release_en_i = '0;
    out_ready_i = 1'b0;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    fd = $fopen(test_file, "r");
    if (fd == 0) begin
      $display("Could not open the test data file %0s", test_file);
      $display("tests failed");
      $fatal(1, "no test data");
    end else begin
      while ($fscanf(fd, "%s", name) == 1) begin
        if (name == name_t'("#")) begin
          rc = $fgets(skip, fd);
        end else begin
          rc = $fscanf(fd, "%s", op);
          case (op)
            "R": begin
              rc = $fscanf(fd, "%d %d", f_id, f_slot);
              reserve_slot(name, f_id, f_slot);
            end
            "W": begin
              rc = $fscanf(fd, "%h %d", f_msg, f_num);
              write_msg(name, f_msg, f_num != 0);
            end
            "L": begin
              rc = $fscanf(fd, "%d", n_en);
              for (int i = 0; i < n_en; i++) begin
                rc = $fscanf(fd, "%d", en_list[slot_idx_t'(i)]);
              end
              rc = $fscanf(fd, "%d %d", stall, n_out);
              for (int k = 0; k < n_out; k++) begin
                rc = $fscanf(fd, "%h %d", exp_msgs[slot_idx_t'(k)], exp_slots[slot_idx_t'(k)]);
              end
              release_slots(name, n_en, stall, n_out);
            end
            "N": begin
              rc = $fscanf(fd, "%d %d", f_slot, f_num);
              expect_no_output(name, f_slot, f_num);
            end
            "F": begin
              rc = $fscanf(fd, "%d %d", f_id, f_num);
              fill_bank(name, f_id, f_num);
            end
            default: begin
              $display("Unknown command letter in test %0s", name);
              $display("tests failed");
              $fatal(1, "bad test data");
            end
          endcase
        end
      end
      $fclose(fd);
      $display("all tests passed");
      $finish;
    end
  end

  // Run time budget of 100 cycles per line of the test file
  initial begin : watchdog
    int               wfd;
    int               lines;
    logic [8*128-1:0] line_buf;

    lines = 0;
    wfd = $fopen(test_file, "r");
    if (wfd != 0) begin
      while ($fgets(line_buf, wfd) != 0) begin
        lines++;
      end
      $fclose(wfd);
    end
    repeat (lines * 100) @(posedge clk_i);
    $display("Watchdog expired before the test file was finished");
    $display("tests failed");
    $fatal(1, "timeout");
  end

endmodule

// File: bench/simmem_tests.txt
# name op fields | R: id slot | W: msg_hex ready | N: slot cycles | F: id count
# L: n_en slots... stall n_out then msg_hex slot per output
lowest_0    R 3 0
lowest_1    R 3 1
lowest_2    R 3 2
order_w0    W 11110003 1
order_w1    W 22220003 1
order_w2    W 33330003 1
order_rel   L 3 0 1 2 0 3 11110003 0 22220003 1 33330003 2
arb_rsv_id2 R 2 0
arb_rsv_id1 R 1 1
arb_w_id2   W aaaa0002 1
arb_w_id1   W bbbb0001 1
arb_rel     L 2 0 1 0 2 bbbb0001 1 aaaa0002 0
gate_no_rsv W 00000001 0
gate_rsv    R 0 0
gate_unfill N 0 20
gate_fill   W cccc0000 1
bp_rsv      R 1 1
bp_w        W dddd0001 1
bp_rel      L 1 1 4 1 dddd0001 1
reuse_rsv   R 1 1
fill_all    F 2 6

// File: simmem_resp_bank.f
+incdir+rtl
rtl/simmem_pkg.sv
rtl/simmem_slot_alloc.sv
rtl/simmem_id_queues.sv
rtl/simmem_msg_store.sv
rtl/simmem_release_sel.sv
rtl/simmem_resp_bank.sv
bench/simmem_resp_bank_chk.sv
bench/simmem_resp_bank_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the write-response bank testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f simmem_resp_bank.f \
  --top-module simmem_resp_bank_tb -Mdir obj_dir -o simmem_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "Verilator build failed, see build.log"
  exit 1
fi

./obj_dir/simmem_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "tests failed" sim.log; then
  echo "Simulation FAILED"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulation FAILED with exit status $sim_status"
  exit 1
fi
echo "Simulation PASSED"
exit 0
